/* hw/turf_udp_cfg.svh */
`ifndef TURF_UDP_CFG_SVH
`define TURF_UDP_CFG_SVH

// Read/write port range 'Tp'..'Tw', matched with the low bits masked
`define TURF_RW_BASE_PORT 21616
`define TURF_RW_PORT_MASK 7

// Exact read port ('Tr'), also the read reply tag
`define TURF_RD_PORT 21618
// Write reply tag ('Tw')
`define TURF_WR_PORT 21623

// Stream and register bus widths
`define TURF_PAYLOAD_W 64
`define TURF_PORT_W 16
`define TURF_ADR_W 28
`define TURF_DAT_W 32

`endif

/* hw/turf_udp_pkg.sv */
`default_nettype none
`include "turf_udp_cfg.svh"

package turf_udp_pkg;

    // UDP header word, always 64 bits regardless of payload width
    typedef logic [63:0] udp_hdr_t;
    typedef logic [`TURF_PORT_W-1:0] udp_port_t;

    // Payload beat and its byte keep
    typedef logic [`TURF_PAYLOAD_W-1:0] udp_data_t;
    typedef logic [`TURF_PAYLOAD_W/8-1:0] udp_keep_t;

    // Register bus
    typedef logic [`TURF_ADR_W-1:0] reg_adr_t;
    typedef logic [`TURF_DAT_W-1:0] reg_dat_t;

    // Read/write core states
    typedef enum logic [1:0] {
        IDLE,
        HDR_OUT,
        BUS,
        RESP
    } rdwr_state_e;

endpackage

`default_nettype wire

/* hw/udp_port_switch.sv */
`timescale 1ns/10ps
`default_nettype none
`include "turf_udp_cfg.svh"

module udp_port_switch (
    input  wire                         clk156_i,
    input  wire                         rst_n_i,
    // Inbound header
    input  wire turf_udp_pkg::udp_hdr_t  s_hdr_tdata_i,
    input  wire turf_udp_pkg::udp_port_t s_hdr_tdest_i,
    input  wire                         s_hdr_tvalid_i,
    output logic                        s_hdr_tready_o,
    // Inbound payload
    input  wire turf_udp_pkg::udp_data_t s_data_tdata_i,
    input  wire turf_udp_pkg::udp_keep_t s_data_tkeep_i,
    input  wire                         s_data_tlast_i,
    input  wire                         s_data_tvalid_i,
    output logic                        s_data_tready_o,
    // Header to the read/write core
    output turf_udp_pkg::udp_hdr_t       rw_hdr_tdata_o,
    output logic                        rw_hdr_tuser_o,
    output logic                        rw_hdr_tvalid_o,
    input  wire                         rw_hdr_tready_i,
    // Payload to the read/write core
    output turf_udp_pkg::udp_data_t      rw_data_tdata_o,
    output logic                        rw_data_tlast_o,
    output logic                        rw_data_tvalid_o,
    input  wire                         rw_data_tready_i
);
    import turf_udp_pkg::*;

    localparam udp_port_t RW_BASE = `TURF_RW_BASE_PORT;
    localparam udp_port_t RW_MASK = `TURF_RW_PORT_MASK;
    localparam udp_port_t RD_PORT = `TURF_RD_PORT;

    logic     hdr_rdy_q;
    logic     pkt_q;
    logic     route_core_q;
    logic     hdr_vld_q;
    logic     hdr_rd_q;
    udp_hdr_t hdr_q;

    logic     port_match;
    logic     hdr_xfer;
    logic     last_xfer;
    logic     pkt_d;

    // Masked compare takes 'Tr' and the whole 'Tw' family in one go
    assign port_match = (s_hdr_tdest_i & ~RW_MASK) == (RW_BASE & ~RW_MASK);

    assign hdr_xfer  = s_hdr_tvalid_i & hdr_rdy_q;
    assign last_xfer = s_data_tvalid_i & s_data_tready_o & s_data_tlast_i;
    assign pkt_d     = hdr_xfer ? 1'b1 : (last_xfer ? 1'b0 : pkt_q);

    always_ff @(posedge clk156_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pkt_q        <= 1'b0;
            hdr_rdy_q    <= 1'b0;
            route_core_q <= 1'b0;
            hdr_vld_q    <= 1'b0;
        end else begin
            pkt_q <= pkt_d;
            // No new header until the last beat of this packet is gone
            hdr_rdy_q <= ~pkt_d;
            if (hdr_xfer) begin
                route_core_q <= port_match;
            end
            if (hdr_xfer && port_match) begin
                hdr_vld_q <= 1'b1;
            end else if (rw_hdr_tready_i) begin
                hdr_vld_q <= 1'b0;
            end
        end
    end

    // One-entry header register toward the core
    always_ff @(posedge clk156_i) begin
        if (hdr_xfer && port_match) begin
            hdr_q    <= s_hdr_tdata_i;
            hdr_rd_q <= (s_hdr_tdest_i == RD_PORT);
        end
    end

    assign s_hdr_tready_o  = hdr_rdy_q;
    assign rw_hdr_tdata_o  = hdr_q;
    assign rw_hdr_tuser_o  = hdr_rd_q;
    assign rw_hdr_tvalid_o = hdr_vld_q;

    // Payload steering; unmatched packets are sunk so upstream never stalls.
    // s_data_tkeep_i is not forwarded, each request beat is a whole word
    assign rw_data_tdata_o  = s_data_tdata_i;
    assign rw_data_tlast_o  = s_data_tlast_i;
    assign rw_data_tvalid_o = s_data_tvalid_i & pkt_q & route_core_q;
    assign s_data_tready_o  = pkt_q & (route_core_q ? rw_data_tready_i : 1'b1);

endmodule

`default_nettype wire

/* hw/udp_rdwr_core.sv */
`timescale 1ns/10ps
`default_nettype none
`include "turf_udp_cfg.svh"

module udp_rdwr_core (
    input  wire                         clk156_i,
    input  wire                         rst_n_i,
    // Request header, tuser high for a read
    input  wire turf_udp_pkg::udp_hdr_t  s_hdr_tdata_i,
    input  wire                         s_hdr_tuser_i,
    input  wire                         s_hdr_tvalid_i,
    output logic                        s_hdr_tready_o,
    // Request payload
    input  wire turf_udp_pkg::udp_data_t s_data_tdata_i,
    input  wire                         s_data_tlast_i,
    input  wire                         s_data_tvalid_i,
    output logic                        s_data_tready_o,
    // Reply header with port tag
    output turf_udp_pkg::udp_hdr_t       m_hdr_tdata_o,
    output turf_udp_pkg::udp_port_t      m_hdr_tuser_o,
    output logic                        m_hdr_tvalid_o,
    input  wire                         m_hdr_tready_i,
    // Reply payload
    output turf_udp_pkg::udp_data_t      m_data_tdata_o,
    output turf_udp_pkg::udp_keep_t      m_data_tkeep_o,
    output logic                        m_data_tlast_o,
    output logic                        m_data_tvalid_o,
    input  wire                         m_data_tready_i,
    // Register bus
    output logic                        en_o,
    output logic                        wr_o,
    output turf_udp_pkg::reg_adr_t       adr_o,
    output turf_udp_pkg::reg_dat_t       dat_o,
    input  wire turf_udp_pkg::reg_dat_t  dat_i,
    input  wire                         ack_i
);
    import turf_udp_pkg::*;

    localparam udp_port_t RD_PORT = `TURF_RD_PORT;
    localparam udp_port_t WR_PORT = `TURF_WR_PORT;

    rdwr_state_e state_q;

    logic     hdr_vld_q;
    logic     rd_q;
    logic     en_q;
    logic     rsp_vld_q;

    udp_hdr_t hdr_q;
    reg_dat_t req_lo_q;
    reg_dat_t wdat_q;
    reg_dat_t rsp_dat_q;
    logic     last_q;

    logic     hdr_xfer;
    logic     req_xfer;
    logic     rsp_xfer;
    logic     bus_done;

    assign s_hdr_tready_o = (state_q == IDLE);
    // Request beats only once the reply header has gone out
    assign s_data_tready_o = (state_q == HDR_OUT) & ~hdr_vld_q;

    assign hdr_xfer = s_hdr_tvalid_i & s_hdr_tready_o;
    assign req_xfer = s_data_tvalid_i & s_data_tready_o;
    assign rsp_xfer = rsp_vld_q & m_data_tready_i;
    assign bus_done = (state_q == BUS) & ack_i;

    always_ff @(posedge clk156_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            hdr_vld_q <= 1'b0;
            rd_q      <= 1'b0;
            en_q      <= 1'b0;
            rsp_vld_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (hdr_xfer) begin
                        rd_q      <= s_hdr_tuser_i;
                        hdr_vld_q <= 1'b1;
                        state_q   <= HDR_OUT;
                    end
                end
                HDR_OUT: begin
                    // Also the wait for the next beat of a longer packet
                    if (m_hdr_tready_i) begin
                        hdr_vld_q <= 1'b0;
                    end
                    if (req_xfer) begin
                        en_q    <= 1'b1;
                        state_q <= BUS;
                    end
                end
                BUS: begin
                    if (ack_i) begin
                        en_q      <= 1'b0;
                        rsp_vld_q <= 1'b1;
                        state_q   <= RESP;
                    end
                end
                RESP: begin
                    if (rsp_xfer) begin
                        rsp_vld_q <= 1'b0;
                        state_q   <= last_q ? IDLE : HDR_OUT;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Header, request and response words
    always_ff @(posedge clk156_i) begin
        if (hdr_xfer) begin
            hdr_q <= s_hdr_tdata_i;
        end
        if (req_xfer) begin
            req_lo_q <= s_data_tdata_i[`TURF_DAT_W-1:0];
            wdat_q   <= s_data_tdata_i[`TURF_PAYLOAD_W-1:`TURF_DAT_W];
            last_q   <= s_data_tlast_i;
        end
        // Reads return the bus data, writes echo what was written
        if (bus_done) begin
            rsp_dat_q <= rd_q ? dat_i : wdat_q;
        end
    end

    assign m_hdr_tdata_o  = hdr_q;
    assign m_hdr_tuser_o  = rd_q ? RD_PORT : WR_PORT;
    assign m_hdr_tvalid_o = hdr_vld_q;

    assign m_data_tdata_o  = {rsp_dat_q, req_lo_q};
    assign m_data_tkeep_o  = '1;
    assign m_data_tlast_o  = last_q;
    assign m_data_tvalid_o = rsp_vld_q;

    // Bus signals held from registers for the whole cycle
    assign en_o  = en_q;
    assign wr_o  = ~rd_q;
    assign adr_o = req_lo_q[`TURF_ADR_W-1:0];
    assign dat_o = wdat_q;

endmodule

`default_nettype wire

/* hw/turf_udp_wrap.sv */
`timescale 1ns/10ps
`default_nettype none
`include "turf_udp_cfg.svh"

module turf_udp_wrap (
    input  wire                         clk156_i,
    input  wire                         rst_n_i,
    // Inbound UDP header and payload
    input  wire turf_udp_pkg::udp_hdr_t  s_hdr_tdata_i,
    input  wire turf_udp_pkg::udp_port_t s_hdr_tdest_i,
    input  wire                         s_hdr_tvalid_i,
    output logic                        s_hdr_tready_o,
    input  wire turf_udp_pkg::udp_data_t s_data_tdata_i,
    input  wire turf_udp_pkg::udp_keep_t s_data_tkeep_i,
    input  wire                         s_data_tlast_i,
    input  wire                         s_data_tvalid_i,
    output logic                        s_data_tready_o,
    // Outbound UDP header and payload
    output turf_udp_pkg::udp_hdr_t       m_hdr_tdata_o,
    output turf_udp_pkg::udp_port_t      m_hdr_tuser_o,
    output logic                        m_hdr_tvalid_o,
    input  wire                         m_hdr_tready_i,
    output turf_udp_pkg::udp_data_t      m_data_tdata_o,
    output turf_udp_pkg::udp_keep_t      m_data_tkeep_o,
    output logic                        m_data_tlast_o,
    output logic                        m_data_tvalid_o,
    input  wire                         m_data_tready_i,
    // Register bus
    output logic                        en_o,
    output logic                        wr_o,
    output turf_udp_pkg::reg_adr_t       adr_o,
    output turf_udp_pkg::reg_dat_t       dat_o,
    input  wire turf_udp_pkg::reg_dat_t  dat_i,
    input  wire                         ack_i
);
    import turf_udp_pkg::*;

    // Switch to core
    wire udp_hdr_t  rw_hdr_tdata;
    wire            rw_hdr_tuser;
    wire            rw_hdr_tvalid;
    wire            rw_hdr_tready;
    wire udp_data_t rw_data_tdata;
    wire            rw_data_tlast;
    wire            rw_data_tvalid;
    wire            rw_data_tready;

    udp_port_switch u_port_switch (
        .clk156_i         (clk156_i),
        .rst_n_i          (rst_n_i),
        .s_hdr_tdata_i    (s_hdr_tdata_i),
        .s_hdr_tdest_i    (s_hdr_tdest_i),
        .s_hdr_tvalid_i   (s_hdr_tvalid_i),
        .s_hdr_tready_o   (s_hdr_tready_o),
        .s_data_tdata_i   (s_data_tdata_i),
        .s_data_tkeep_i   (s_data_tkeep_i),
        .s_data_tlast_i   (s_data_tlast_i),
        .s_data_tvalid_i  (s_data_tvalid_i),
        .s_data_tready_o  (s_data_tready_o),
        .rw_hdr_tdata_o   (rw_hdr_tdata),
        .rw_hdr_tuser_o   (rw_hdr_tuser),
        .rw_hdr_tvalid_o  (rw_hdr_tvalid),
        .rw_hdr_tready_i  (rw_hdr_tready),
        .rw_data_tdata_o  (rw_data_tdata),
        .rw_data_tlast_o  (rw_data_tlast),
        .rw_data_tvalid_o (rw_data_tvalid),
        .rw_data_tready_i (rw_data_tready)
    );

    // The core drives the outbound stream directly
    udp_rdwr_core u_rdwr (
        .clk156_i        (clk156_i),
        .rst_n_i         (rst_n_i),
        .s_hdr_tdata_i   (rw_hdr_tdata),
        .s_hdr_tuser_i   (rw_hdr_tuser),
        .s_hdr_tvalid_i  (rw_hdr_tvalid),
        .s_hdr_tready_o  (rw_hdr_tready),
        .s_data_tdata_i  (rw_data_tdata),
        .s_data_tlast_i  (rw_data_tlast),
        .s_data_tvalid_i (rw_data_tvalid),
        .s_data_tready_o (rw_data_tready),
        .m_hdr_tdata_o   (m_hdr_tdata_o),
        .m_hdr_tuser_o   (m_hdr_tuser_o),
        .m_hdr_tvalid_o  (m_hdr_tvalid_o),
        .m_hdr_tready_i  (m_hdr_tready_i),
        .m_data_tdata_o  (m_data_tdata_o),
        .m_data_tkeep_o  (m_data_tkeep_o),
        .m_data_tlast_o  (m_data_tlast_o),
        .m_data_tvalid_o (m_data_tvalid_o),
        .m_data_tready_i (m_data_tready_i),
        .en_o            (en_o),
        .wr_o            (wr_o),
        .adr_o           (adr_o),
        .dat_o           (dat_o),
        .dat_i           (dat_i),
        .ack_i           (ack_i)
    );

endmodule

`default_nettype wire

/* tb/turf_udp_checker.sv */
`timescale 1ns/10ps
`default_nettype none
`include "turf_udp_cfg.svh"

module turf_udp_checker (
    input wire                          clk156_i,
    input wire                          rst_n_i,
    input wire turf_udp_pkg::udp_hdr_t  m_hdr_tdata_o,
    input wire turf_udp_pkg::udp_port_t m_hdr_tuser_o,
    input wire                          m_hdr_tvalid_o,
    input wire                          m_hdr_tready_i,
    input wire turf_udp_pkg::udp_data_t m_data_tdata_o,
    input wire                          m_data_tlast_o,
    input wire                          m_data_tvalid_o,
    input wire                          m_data_tready_i,
    input wire                          en_o,
    input wire                          wr_o,
    input wire turf_udp_pkg::reg_adr_t  adr_o,
    input wire turf_udp_pkg::reg_dat_t  dat_o,
    input wire                          ack_i
);
    import turf_udp_pkg::*;

    logic hdr_seen_q;

    // Set by a reply header, cleared by the last reply beat
    always_ff @(posedge clk156_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hdr_seen_q <= 1'b0;
        end else if (m_hdr_tvalid_o && m_hdr_tready_i) begin
            hdr_seen_q <= 1'b1;
        end else if (m_data_tvalid_o && m_data_tready_i && m_data_tlast_o) begin
            hdr_seen_q <= 1'b0;
        end
    end

    hdr_stable: assert property (@(posedge clk156_i) disable iff (!rst_n_i)
        m_hdr_tvalid_o && !m_hdr_tready_i |=>
            m_hdr_tvalid_o && $stable(m_hdr_tdata_o) && $stable(m_hdr_tuser_o))
        else $error("reply header changed while stalled");

    data_stable: assert property (@(posedge clk156_i) disable iff (!rst_n_i)
        m_data_tvalid_o && !m_data_tready_i |=>
            m_data_tvalid_o && $stable(m_data_tdata_o) && $stable(m_data_tlast_o))
        else $error("reply beat changed while stalled");

    bus_stable: assert property (@(posedge clk156_i) disable iff (!rst_n_i)
        en_o && !ack_i |=>
            en_o && $stable(wr_o) && $stable(adr_o) && $stable(dat_o))
        else $error("bus request changed before ack");

    data_after_hdr: assert property (@(posedge clk156_i) disable iff (!rst_n_i)
        m_data_tvalid_o |-> hdr_seen_q)
        else $error("reply beat before its header");

endmodule

bind turf_udp_wrap turf_udp_checker i_checker (
    .clk156_i        (clk156_i),
    .rst_n_i         (rst_n_i),
    .m_hdr_tdata_o   (m_hdr_tdata_o),
    .m_hdr_tuser_o   (m_hdr_tuser_o),
    .m_hdr_tvalid_o  (m_hdr_tvalid_o),
    .m_hdr_tready_i  (m_hdr_tready_i),
    .m_data_tdata_o  (m_data_tdata_o),
    .m_data_tlast_o  (m_data_tlast_o),
    .m_data_tvalid_o (m_data_tvalid_o),
    .m_data_tready_i (m_data_tready_i),
    .en_o            (en_o),
    .wr_o            (wr_o),
    .adr_o           (adr_o),
    .dat_o           (dat_o),
    .ack_i           (ack_i)
);

`default_nettype wire

/* tb/turf_udp_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "turf_udp_cfg.svh"

module turf_udp_tb;
    import turf_udp_pkg::*;

    localparam udp_port_t RW_BASE = `TURF_RW_BASE_PORT;
    localparam udp_port_t RW_MASK = `TURF_RW_PORT_MASK;
    localparam udp_port_t RD_PORT = `TURF_RD_PORT;
    localparam udp_port_t WR_PORT = `TURF_WR_PORT;

    logic      clk156_i;
    logic      rst_n_i;
    udp_hdr_t  s_hdr_tdata_i;
    udp_port_t s_hdr_tdest_i;
    logic      s_hdr_tvalid_i;
    logic      s_hdr_tready_o;
    udp_data_t s_data_tdata_i;
    udp_keep_t s_data_tkeep_i;
    logic      s_data_tlast_i;
    logic      s_data_tvalid_i;
    logic      s_data_tready_o;
    udp_hdr_t  m_hdr_tdata_o;
    udp_port_t m_hdr_tuser_o;
    logic      m_hdr_tvalid_o;
    logic      m_hdr_tready_i;
    udp_data_t m_data_tdata_o;
    udp_keep_t m_data_tkeep_o;
    logic      m_data_tlast_o;
    logic      m_data_tvalid_o;
    logic      m_data_tready_i;
    logic      en_o;
    logic      wr_o;
    reg_adr_t  adr_o;
    reg_dat_t  dat_o;
    reg_dat_t  dat_i;
    logic      ack_i;

    logic [15:0] lfsr = 16'd20691;
    int          errors = 0;
    int          bus_count = 0;
    int          bus_expected = 0;
    int          total_beats = 0;
    logic        gen_done = 1'b0;
    logic        gaps_en = 1'b0;

    // Stimulus, generated up front together with the model's answers
    int        pkt_test[$];
    udp_port_t pkt_port[$];
    udp_hdr_t  pkt_hdr[$];
    int        pkt_len[$];
    udp_data_t beat_req[$];
    udp_data_t beat_rsp[$];
    reg_dat_t  mem_model[reg_adr_t];

    // Expected outputs, pushed as each packet is sent
    udp_hdr_t  exp_hdr_q[$];
    udp_port_t exp_tag_q[$];
    udp_data_t exp_beat_q[$];
    logic      exp_last_q[$];
    logic      exp_wr_q[$];
    reg_adr_t  exp_adr_q[$];
    reg_dat_t  exp_dat_q[$];

    // Register file seen by the bus
    reg_dat_t  regs[reg_adr_t];
    logic      bus_busy = 1'b0;
    int        ack_wait = 0;

    turf_udp_wrap i_turf_udp_wrap (.*);

    initial begin
        clk156_i = 1'b0;
        forever #4 clk156_i = ~clk156_i;
    end

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Read/write ports span 21616 to 21623
    function automatic logic is_rw_port(input udp_port_t p);
        return (p >= RW_BASE) && (p <= RW_BASE + RW_MASK);
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act)
        else begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic gen_packet(input int test_id, input udp_port_t port);
        logic [63:0] r;
        udp_data_t   d;
        reg_adr_t    adr;
        reg_dat_t    rsp;
        int          n;
        r = rand_bits(2);
        n = int'(r) + 1;
        pkt_test.push_back(test_id);
        pkt_port.push_back(port);
        pkt_hdr.push_back(rand_bits(64));
        pkt_len.push_back(n);
        total_beats += n + 1;
        for (int i = 0; i < n; i++) begin
            // A small address window so that reads hit earlier writes
            r = rand_bits(4);
            adr = {24'h5A0C3E, r[3:0]};
            r = rand_bits(36);
            d = {r[35:4], r[3:0], adr};
            rsp = d[63:32];
            if (is_rw_port(port) && port == RD_PORT) begin
                rsp = mem_model.exists(adr) ? mem_model[adr] : '0;
            end else if (is_rw_port(port)) begin
                mem_model[adr] = d[63:32];
            end
            beat_req.push_back(d);
            beat_rsp.push_back({rsp, d[31:0]});
        end
    endtask

    function automatic udp_port_t pick_port();
        logic [63:0] r;
        udp_port_t   p;
        r = rand_bits(2);
        case (r[1:0])
            2'd0: p = RD_PORT;
            2'd1: begin
                r = rand_bits(3);
                p = RW_BASE | udp_port_t'(r[2:0]);
                if (p == RD_PORT) p = WR_PORT;
            end
            2'd2: begin
                r = rand_bits(16);
                p = r[15:0];
                if (is_rw_port(p)) p = p ^ 16'h8000;
            end
            default: p = WR_PORT;
        endcase
        return p;
    endfunction

    task automatic send_packet(inout int pi, inout int bi);
        udp_port_t port;
        logic      rd;
        int        n;
        logic [63:0] r;
        port = pkt_port[pi];
        rd = (port == RD_PORT);
        n = pkt_len[pi];
        if (is_rw_port(port)) begin
            exp_hdr_q.push_back(pkt_hdr[pi]);
            exp_tag_q.push_back(rd ? RD_PORT : WR_PORT);
            for (int i = 0; i < n; i++) begin
                exp_beat_q.push_back(beat_rsp[bi + i]);
                exp_last_q.push_back(i == n - 1);
                exp_wr_q.push_back(!rd);
                exp_adr_q.push_back(beat_req[bi + i][`TURF_ADR_W-1:0]);
                exp_dat_q.push_back(beat_req[bi + i][63:32]);
                bus_expected++;
            end
        end
        s_hdr_tdata_i = pkt_hdr[pi];
        s_hdr_tdest_i = port;
        s_hdr_tvalid_i = 1'b1;
        #1;
        while (!s_hdr_tready_o) begin
            @(negedge clk156_i);
            #1;
        end
        @(negedge clk156_i);
        s_hdr_tvalid_i = 1'b0;
        for (int i = 0; i < n; i++) begin
            r = rand_bits(8);
            s_data_tdata_i = beat_req[bi + i];
            s_data_tkeep_i = r[7:0];
            s_data_tlast_i = (i == n - 1);
            s_data_tvalid_i = 1'b1;
            #1;
            while (!s_data_tready_o) begin
                @(negedge clk156_i);
                #1;
            end
            @(negedge clk156_i);
        end
        s_data_tvalid_i = 1'b0;
        s_data_tlast_i = 1'b0;
        pi++;
        bi += n;
    endtask

    task automatic run_test(input int id, input string name, inout int pi, inout int bi);
        int start_err;
        start_err = errors;
        gaps_en = (id >= 5);
        while (pi < pkt_test.size() && pkt_test[pi] == id) begin
            send_packet(pi, bi);
        end
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0 || en_o) begin
            @(negedge clk156_i);
        end
        repeat (4) @(negedge clk156_i);
        $display("Test %0d %s: %0d errors", id, name, errors - start_err);
    endtask

    // Reply stream monitor; ready is decided at the falling edge
    always @(negedge clk156_i) begin
        if (rst_n_i) begin
            // Ready drawn first, it is the one the next rising edge sees
            m_hdr_tready_i = gaps_en ? (rand_bits(2) != 0) : 1'b1;
            m_data_tready_i = gaps_en ? (rand_bits(2) != 0) : 1'b1;
            if (m_hdr_tvalid_o && m_hdr_tready_i) begin
                if (exp_hdr_q.size() == 0) begin
                    $display("Reply header appeared with no request pending");
                    errors++;
                end else begin
                    check_val("m_hdr_tdata_o", exp_hdr_q.pop_front(), m_hdr_tdata_o);
                    check_val("m_hdr_tuser_o", 64'(exp_tag_q.pop_front()), 64'(m_hdr_tuser_o));
                end
            end
            if (m_data_tvalid_o && m_data_tready_i) begin
                if (exp_beat_q.size() == 0) begin
                    $display("Reply beat appeared with no request pending");
                    errors++;
                end else begin
                    check_val("m_data_tdata_o", exp_beat_q.pop_front(), m_data_tdata_o);
                    check_val("m_data_tlast_o", 64'(exp_last_q.pop_front()),
                              64'(m_data_tlast_o));
                    check_val("m_data_tkeep_o", 64'hFF, 64'(m_data_tkeep_o));
                end
            end
        end
    end

    // Register bus responder with random ack delay
    always @(negedge clk156_i) begin
        if (ack_i) begin
            ack_i = 1'b0;
        end else if (rst_n_i && en_o) begin
            if (!bus_busy) begin
                bus_busy = 1'b1;
                ack_wait = int'(rand_bits(2));
                if (exp_wr_q.size() == 0) begin
                    $display("Bus cycle started with no request pending");
                    errors++;
                end else begin
                    check_val("wr_o", 64'(exp_wr_q.pop_front()), 64'(wr_o));
                    check_val("adr_o", 64'(exp_adr_q.pop_front()), 64'(adr_o));
                    if (wr_o) begin
                        check_val("dat_o", 64'(exp_dat_q.pop_front()), 64'(dat_o));
                    end else begin
                        void'(exp_dat_q.pop_front());
                    end
                end
            end
            if (ack_wait == 0) begin
                dat_i = regs.exists(adr_o) ? regs[adr_o] : '0;
                if (wr_o) regs[adr_o] = dat_o;
                ack_i = 1'b1;
                bus_busy = 1'b0;
                bus_count++;
            end else begin
                ack_wait--;
            end
        end
    end

    // Watchdog sized from the generated traffic
    initial begin
        wait (gen_done);
        repeat (total_beats * 40 + 200) @(posedge clk156_i);
        $display("Timeout: the DUT stopped answering");
        $display("Test failed");
        $finish;
    end

    initial begin
        int          pi;
        int          bi;
        int          start_err;
        logic [63:0] r;
        udp_port_t   p;
        rst_n_i = 1'b0;
        s_hdr_tdata_i = '0;
        s_hdr_tdest_i = '0;
        s_hdr_tvalid_i = 1'b0;
        s_data_tdata_i = '0;
        s_data_tkeep_i = '0;
        s_data_tlast_i = 1'b0;
        s_data_tvalid_i = 1'b0;
        m_hdr_tready_i = 1'b1;
        m_data_tready_i = 1'b1;
        dat_i = '0;
        ack_i = 1'b0;
        pi = 0;
        bi = 0;

        for (int i = 0; i < 6; i++) begin
            r = rand_bits(3);
            p = RW_BASE | udp_port_t'(r[2:0]);
            gen_packet(2, (p == RD_PORT) ? WR_PORT : p);
        end
        for (int i = 0; i < 6; i++) begin
            gen_packet(3, (i % 2 == 0) ? RD_PORT : WR_PORT);
        end
        gen_packet(4, 16'd21601);
        gen_packet(4, 16'd21603);
        gen_packet(4, 16'd21614);
        for (int i = 0; i < 3; i++) begin
            r = rand_bits(16);
            p = r[15:0];
            gen_packet(4, is_rw_port(p) ? (p ^ 16'h8000) : p);
        end
        gen_packet(4, WR_PORT);
        gen_packet(4, RD_PORT);
        for (int i = 0; i < 8; i++) gen_packet(5, pick_port());
        for (int i = 0; i < 30; i++) gen_packet(6, pick_port());
        gen_done = 1'b1;

        repeat (4) @(negedge clk156_i);
        rst_n_i = 1'b1;

        // Quiet outputs after reset
        start_err = errors;
        repeat (20) begin
            @(negedge clk156_i);
            assert (!m_hdr_tvalid_o && !m_data_tvalid_o && !en_o)
            else begin
                $display("Output became active with no input");
                errors++;
            end
        end
        $display("Test 1 reset: %0d errors", errors - start_err);

        run_test(2, "writes", pi, bi);
        run_test(3, "reads", pi, bi);
        run_test(4, "discarded ports", pi, bi);
        run_test(5, "back-pressure", pi, bi);
        run_test(6, "mixed traffic", pi, bi);
        check_val("bus cycle count", 64'(bus_expected), 64'(bus_count));

        $display("Checks done: %0d errors, %0d bus cycles", errors, bus_count);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/turf_udp_pkg.sv
hw/udp_port_switch.sv
hw/udp_rdwr_core.sv
hw/turf_udp_wrap.sv
tb/turf_udp_checker.sv
tb/turf_udp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the turf_udp testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module turf_udp_tb \
    -f verilog.f \
    -o sim_turf_udp
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_turf_udp > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
